//--- source/cuPkg.sv
package cuPkg;

  // Instruction fields
  localparam int OpcodeWidth = 6;
  localparam int FunctWidth = 6;

  localparam int OpWidth = 5;
  localparam int StateWidth = 4;

  // Control word field widths
  localparam int AluOpWidth = 3;
  localparam int SrcBWidth = 2;
  localparam int RegDstWidth = 2;
  localparam int MemToRegWidth = 4;
  localparam int AddrSrcWidth = 3;
  localparam int PcSourceWidth = 2;

  typedef enum logic [OpWidth-1:0] {
    opAdd, opSub, opAnd, opSlt, opJr, opMfhi, opMflo, opBreak, opRte,
    opAddi, opAddiu, opSlti, opLui, opSw, opJ, opJal, opInvalid
  } cuOp;

  typedef enum logic [StateWidth-1:0] {
    stReset, stFetchWait, stFetchPc, stIrLoad, stDecode,
    stExecute, stOverflow, stInvalid
  } cuState;

  // Opcodes
  localparam logic [OpcodeWidth-1:0] opcodeR = 6'b000000;
  localparam logic [OpcodeWidth-1:0] opcodeJ = 6'b000010;
  localparam logic [OpcodeWidth-1:0] opcodeJal = 6'b000011;
  localparam logic [OpcodeWidth-1:0] opcodeAddi = 6'b001000;
  localparam logic [OpcodeWidth-1:0] opcodeAddiu = 6'b001001;
  localparam logic [OpcodeWidth-1:0] opcodeSlti = 6'b001010;
  localparam logic [OpcodeWidth-1:0] opcodeLui = 6'b001111;
  localparam logic [OpcodeWidth-1:0] opcodeSw = 6'b101011;

  // R type funct values
  localparam logic [FunctWidth-1:0] functJr = 6'b001000;
  localparam logic [FunctWidth-1:0] functBreak = 6'b001101;
  localparam logic [FunctWidth-1:0] functMfhi = 6'b010000;
  localparam logic [FunctWidth-1:0] functMflo = 6'b010010;
  localparam logic [FunctWidth-1:0] functRte = 6'b010011;
  localparam logic [FunctWidth-1:0] functAdd = 6'b100000;
  localparam logic [FunctWidth-1:0] functSub = 6'b100010;
  localparam logic [FunctWidth-1:0] functAnd = 6'b100100;
  localparam logic [FunctWidth-1:0] functSlt = 6'b101010;

  // ALU operations
  localparam logic [AluOpWidth-1:0] aluNone = 3'd0;
  localparam logic [AluOpWidth-1:0] aluAdd = 3'd1;
  localparam logic [AluOpWidth-1:0] aluSub = 3'd2;
  localparam logic [AluOpWidth-1:0] aluAnd = 3'd3;
  localparam logic [AluOpWidth-1:0] aluSlt = 3'd7;

  localparam logic srcAPc = 1'b0;
  localparam logic srcARegA = 1'b1;

  localparam logic [SrcBWidth-1:0] srcBRegB = 2'd0;
  localparam logic [SrcBWidth-1:0] srcBFour = 2'd1;
  localparam logic [SrcBWidth-1:0] srcBImm = 2'd2;

  localparam logic [RegDstWidth-1:0] dstRt = 2'd0;
  localparam logic [RegDstWidth-1:0] dstRd = 2'd1;
  localparam logic [RegDstWidth-1:0] dstRa = 2'd2;

  // Register write-back sources
  localparam logic [MemToRegWidth-1:0] wbAlu = 4'd0;
  localparam logic [MemToRegWidth-1:0] wbHi = 4'd2;
  localparam logic [MemToRegWidth-1:0] wbLo = 4'd3;
  localparam logic [MemToRegWidth-1:0] wbLui = 4'd8;
  localparam logic [MemToRegWidth-1:0] wbSlt = 4'd10;

  // Memory address sources
  localparam logic [AddrSrcWidth-1:0] addrNone = 3'd0;
  localparam logic [AddrSrcWidth-1:0] addrOvfVector = 3'd1;
  localparam logic [AddrSrcWidth-1:0] addrInvVector = 3'd2;
  localparam logic [AddrSrcWidth-1:0] addrPc = 3'd3;
  localparam logic [AddrSrcWidth-1:0] addrAlu = 3'd4;

  localparam logic [PcSourceWidth-1:0] pcAlu = 2'd0;
  localparam logic [PcSourceWidth-1:0] pcJump = 2'd1;
  localparam logic [PcSourceWidth-1:0] pcMemVector = 2'd2;
  localparam logic [PcSourceWidth-1:0] pcEpc = 2'd3;

endpackage

//--- source/opDecoder.sv
module opDecoder (
  input  logic [cuPkg::OpcodeWidth-1:0] opcode,
  input  logic [cuPkg::FunctWidth-1:0]  funct,
  output cuPkg::cuOp                    op
);

  cuPkg::cuOp rOp;
  cuPkg::cuOp iOp;

  // R type, selected by funct
  always_comb begin
    case (funct)
      cuPkg::functAdd: rOp = cuPkg::opAdd;
      cuPkg::functSub: rOp = cuPkg::opSub;
      cuPkg::functAnd: rOp = cuPkg::opAnd;
      cuPkg::functSlt: rOp = cuPkg::opSlt;
      cuPkg::functJr: rOp = cuPkg::opJr;
      cuPkg::functMfhi: rOp = cuPkg::opMfhi;
      cuPkg::functMflo: rOp = cuPkg::opMflo;
      cuPkg::functBreak: rOp = cuPkg::opBreak;
      cuPkg::functRte: rOp = cuPkg::opRte;
      default: rOp = cuPkg::opInvalid;
    endcase
  end

  // I and J type, selected by opcode
  always_comb begin
    case (opcode)
      cuPkg::opcodeAddi: iOp = cuPkg::opAddi;
      cuPkg::opcodeAddiu: iOp = cuPkg::opAddiu;
      cuPkg::opcodeSlti: iOp = cuPkg::opSlti;
      cuPkg::opcodeLui: iOp = cuPkg::opLui;
      cuPkg::opcodeSw: iOp = cuPkg::opSw;
      cuPkg::opcodeJ: iOp = cuPkg::opJ;
      cuPkg::opcodeJal: iOp = cuPkg::opJal;
      default: iOp = cuPkg::opInvalid;
    endcase
  end

  always_comb begin
    if (opcode == cuPkg::opcodeR) begin
      op = rOp;
    end else begin
      op = iOp;
    end
  end

endmodule

//--- source/phaseSequencer.sv
module phaseSequencer #(
  parameter int FetchWaitCycles = 2
) (
  input  logic          clk,
  input  logic          reset,
  input  cuPkg::cuOp    op,
  input  logic          overflow,
  output cuPkg::cuState state,
  output cuPkg::cuOp    curOp
);

  localparam int CountWidth = (FetchWaitCycles > 1) ? $clog2(FetchWaitCycles) : 1;

  cuPkg::cuState nextState;
  logic [CountWidth-1:0] waitCount;
  logic lastWait;
  logic overflowTrap;

  // Memory read latency at the start of fetch
  assign lastWait = (waitCount == CountWidth'(FetchWaitCycles - 1));

  // Only the signed arithmetic ops trap
  assign overflowTrap = overflow &&
                        (curOp inside {cuPkg::opAdd, cuPkg::opSub, cuPkg::opAddi});

  always_comb begin
    nextState = state;
    case (state)
      cuPkg::stReset: nextState = cuPkg::stFetchWait;
      cuPkg::stFetchWait: begin
        if (lastWait) begin
          nextState = cuPkg::stFetchPc;
        end
      end
      cuPkg::stFetchPc: nextState = cuPkg::stIrLoad;
      cuPkg::stIrLoad: nextState = cuPkg::stDecode;
      cuPkg::stDecode: begin
        if (op == cuPkg::opInvalid) begin
          nextState = cuPkg::stInvalid;
        end else begin
          nextState = cuPkg::stExecute;
        end
      end
      cuPkg::stExecute: begin
        if (overflowTrap) begin
          nextState = cuPkg::stOverflow;
        end else begin
          nextState = cuPkg::stFetchWait;
        end
      end
      cuPkg::stOverflow,
      cuPkg::stInvalid: nextState = cuPkg::stFetchWait;
      default: nextState = cuPkg::stReset;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cuPkg::stReset;
      waitCount <= '0;
      curOp <= cuPkg::opInvalid;
    end else begin
      state <= nextState;
      if (state == cuPkg::stFetchWait && !lastWait) begin
        waitCount <= waitCount + 1'b1;
      end else begin
        waitCount <= '0;
      end
      // Hold the decoded op through execute
      if (state == cuPkg::stDecode) begin
        curOp <= op;
      end
    end
  end

endmodule

//--- source/controlWordGen.sv
module controlWordGen (
  input  cuPkg::cuState                     state,
  input  cuPkg::cuOp                        curOp,
  output logic                              pcWrite,
  output logic                              aWrite,
  output logic                              bWrite,
  output logic                              epcWrite,
  output logic                              irWrite,
  output logic                              regWrite,
  output logic                              memWrite,
  output logic [cuPkg::AluOpWidth-1:0]      aluOp,
  output logic                              aluSrcA,
  output logic [cuPkg::SrcBWidth-1:0]       aluSrcB,
  output logic [cuPkg::RegDstWidth-1:0]     regDst,
  output logic [cuPkg::MemToRegWidth-1:0]   memToReg,
  output logic [cuPkg::AddrSrcWidth-1:0]    addrSrc,
  output logic [cuPkg::PcSourceWidth-1:0]   pcSource,
  output logic                              resetOut
);

  always_comb begin
    pcWrite = 1'b0;
    aWrite = 1'b0;
    bWrite = 1'b0;
    epcWrite = 1'b0;
    irWrite = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    aluOp = cuPkg::aluNone;
    aluSrcA = cuPkg::srcAPc;
    aluSrcB = cuPkg::srcBRegB;
    regDst = cuPkg::dstRt;
    memToReg = cuPkg::wbAlu;
    addrSrc = cuPkg::addrNone;
    pcSource = cuPkg::pcAlu;
    resetOut = 1'b0;

    case (state)
      cuPkg::stReset: resetOut = 1'b1;
      cuPkg::stFetchWait: addrSrc = cuPkg::addrPc;
      cuPkg::stFetchPc: begin
        // PC + 4
        pcWrite = 1'b1;
        aluOp = cuPkg::aluAdd;
        aluSrcB = cuPkg::srcBFour;
      end
      cuPkg::stIrLoad: irWrite = 1'b1;
      cuPkg::stDecode: begin
        aWrite = 1'b1;
        bWrite = 1'b1;
      end
      cuPkg::stOverflow,
      cuPkg::stInvalid: begin
        epcWrite = 1'b1;
        pcWrite = 1'b1;
        pcSource = cuPkg::pcMemVector;
        if (state == cuPkg::stOverflow) begin
          addrSrc = cuPkg::addrOvfVector;
        end else begin
          addrSrc = cuPkg::addrInvVector;
        end
      end
      cuPkg::stExecute: begin
        case (curOp)
          cuPkg::opAdd, cuPkg::opSub, cuPkg::opAnd, cuPkg::opSlt: begin
            regWrite = 1'b1;
            aluSrcA = cuPkg::srcARegA;
            regDst = cuPkg::dstRd;
            case (curOp)
              cuPkg::opSub: aluOp = cuPkg::aluSub;
              cuPkg::opAnd: aluOp = cuPkg::aluAnd;
              cuPkg::opSlt: aluOp = cuPkg::aluSlt;
              default: aluOp = cuPkg::aluAdd;
            endcase
            if (curOp == cuPkg::opSlt) begin
              memToReg = cuPkg::wbSlt;
            end
          end
          cuPkg::opAddi, cuPkg::opAddiu, cuPkg::opSlti: begin
            regWrite = 1'b1;
            aluSrcA = cuPkg::srcARegA;
            aluSrcB = cuPkg::srcBImm;
            if (curOp == cuPkg::opSlti) begin
              aluOp = cuPkg::aluSlt;
              memToReg = cuPkg::wbSlt;
            end else begin
              aluOp = cuPkg::aluAdd;
            end
          end
          cuPkg::opLui: begin
            regWrite = 1'b1;
            memToReg = cuPkg::wbLui;
          end
          cuPkg::opMfhi, cuPkg::opMflo: begin
            regWrite = 1'b1;
            regDst = cuPkg::dstRd;
            memToReg = (curOp == cuPkg::opMfhi) ? cuPkg::wbHi : cuPkg::wbLo;
          end
          cuPkg::opSw: begin
            memWrite = 1'b1;
            aluOp = cuPkg::aluAdd;
            aluSrcA = cuPkg::srcARegA;
            aluSrcB = cuPkg::srcBImm;
            addrSrc = cuPkg::addrAlu;
          end
          cuPkg::opJr: begin
            pcWrite = 1'b1;
            aluSrcA = cuPkg::srcARegA;
          end
          cuPkg::opRte: begin
            pcWrite = 1'b1;
            pcSource = cuPkg::pcEpc;
          end
          cuPkg::opBreak: begin
            // Step the PC back to the break itself
            pcWrite = 1'b1;
            aluOp = cuPkg::aluSub;
            aluSrcB = cuPkg::srcBFour;
          end
          cuPkg::opJ, cuPkg::opJal: begin
            pcWrite = 1'b1;
            pcSource = cuPkg::pcJump;
            if (curOp == cuPkg::opJal) begin
              regWrite = 1'b1;
              regDst = cuPkg::dstRa;
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

//--- source/controlUnit.sv
module controlUnit #(
  parameter int FetchWaitCycles = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [cuPkg::OpcodeWidth-1:0]     opcode,
  input  logic [cuPkg::FunctWidth-1:0]      funct,
  input  logic                              overflow,
  output logic                              pcWrite,
  output logic                              aWrite,
  output logic                              bWrite,
  output logic                              epcWrite,
  output logic                              irWrite,
  output logic                              regWrite,
  output logic                              memWrite,
  output logic [cuPkg::AluOpWidth-1:0]      aluOp,
  output logic                              aluSrcA,
  output logic [cuPkg::SrcBWidth-1:0]       aluSrcB,
  output logic [cuPkg::RegDstWidth-1:0]     regDst,
  output logic [cuPkg::MemToRegWidth-1:0]   memToReg,
  output logic [cuPkg::AddrSrcWidth-1:0]    addrSrc,
  output logic [cuPkg::PcSourceWidth-1:0]   pcSource,
  output logic                              resetOut
);

  cuPkg::cuOp op;
  cuPkg::cuOp curOp;
  cuPkg::cuState state;

  opDecoder decoder0 (
    .opcode(opcode),
    .funct(funct),
    .op(op)
  );

  phaseSequencer #(
    .FetchWaitCycles(FetchWaitCycles)
  ) sequencer0 (
    .clk(clk),
    .reset(reset),
    .op(op),
    .overflow(overflow),
    .state(state),
    .curOp(curOp)
  );

  controlWordGen wordGen0 (
    .state(state),
    .curOp(curOp),
    .pcWrite(pcWrite),
    .aWrite(aWrite),
    .bWrite(bWrite),
    .epcWrite(epcWrite),
    .irWrite(irWrite),
    .regWrite(regWrite),
    .memWrite(memWrite),
    .aluOp(aluOp),
    .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB),
    .regDst(regDst),
    .memToReg(memToReg),
    .addrSrc(addrSrc),
    .pcSource(pcSource),
    .resetOut(resetOut)
  );

endmodule

//--- verification/controlUnit_sva.sv
module controlUnit_sva (
  input logic clk,
  input logic reset,
  input logic memWrite,
  input logic regWrite,
  input logic irWrite,
  input logic aWrite,
  input logic epcWrite,
  input logic pcWrite
);

  memRegExclusive: assert property (@(posedge clk) disable iff (reset)
    !(memWrite && regWrite))
    else $error("memWrite and regWrite high in the same cycle");

  // Decode always follows the IR load
  irThenOperands: assert property (@(posedge clk) disable iff (reset)
    irWrite |=> aWrite)
    else $error("aWrite missing one cycle after irWrite");

  epcWithPc: assert property (@(posedge clk) disable iff (reset)
    epcWrite |-> pcWrite)
    else $error("epcWrite high without pcWrite");

endmodule

bind controlUnit controlUnit_sva sva0 (
  .clk(clk),
  .reset(reset),
  .memWrite(memWrite),
  .regWrite(regWrite),
  .irWrite(irWrite),
  .aWrite(aWrite),
  .epcWrite(epcWrite),
  .pcWrite(pcWrite)
);

//--- verification/controlUnitTb.sv
module controlUnitTb;

  localparam int FetchWait = 2;
  localparam int OpCount = 16;
  localparam int InvalidCount = 20;
  localparam int RandomCount = 300;
  localparam int InstrCount = 2 * OpCount + InvalidCount + RandomCount;
  // Longest instruction is FetchWait + 5 cycles
  localparam int Timeout = (InstrCount * 7 + 50) * 4;

  logic clk;
  logic reset;
  logic [cuPkg::OpcodeWidth-1:0] opcode;
  logic [cuPkg::FunctWidth-1:0] funct;
  logic overflow;
  logic pcWrite;
  logic aWrite;
  logic bWrite;
  logic epcWrite;
  logic irWrite;
  logic regWrite;
  logic memWrite;
  logic [cuPkg::AluOpWidth-1:0] aluOp;
  logic aluSrcA;
  logic [cuPkg::SrcBWidth-1:0] aluSrcB;
  logic [cuPkg::RegDstWidth-1:0] regDst;
  logic [cuPkg::MemToRegWidth-1:0] memToReg;
  logic [cuPkg::AddrSrcWidth-1:0] addrSrc;
  logic [cuPkg::PcSourceWidth-1:0] pcSource;
  logic resetOut;
  logic [24:0] gotWord;

  // Reference model state
  cuPkg::cuState expState;
  cuPkg::cuOp expOp;
  int waitCnt;
  int errors;
  int checks;
  int testErrors;
  int testCount;
  int failedTests;

  assign gotWord = {pcWrite, aWrite, bWrite, epcWrite, irWrite, regWrite, memWrite, aluOp,
                    aluSrcA, aluSrcB, regDst, memToReg, addrSrc, pcSource, resetOut};

  controlUnit #(
    .FetchWaitCycles(FetchWait)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .opcode(opcode),
    .funct(funct),
    .overflow(overflow),
    .pcWrite(pcWrite),
    .aWrite(aWrite),
    .bWrite(bWrite),
    .epcWrite(epcWrite),
    .irWrite(irWrite),
    .regWrite(regWrite),
    .memWrite(memWrite),
    .aluOp(aluOp),
    .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB),
    .regDst(regDst),
    .memToReg(memToReg),
    .addrSrc(addrSrc),
    .pcSource(pcSource),
    .resetOut(resetOut)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(Timeout);
    $display("Timeout: the run did not finish within %0d time units", Timeout);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [5:0] opcodeOf(input cuPkg::cuOp o);
    case (o)
      cuPkg::opAddi: return cuPkg::opcodeAddi;
      cuPkg::opAddiu: return cuPkg::opcodeAddiu;
      cuPkg::opSlti: return cuPkg::opcodeSlti;
      cuPkg::opLui: return cuPkg::opcodeLui;
      cuPkg::opSw: return cuPkg::opcodeSw;
      cuPkg::opJ: return cuPkg::opcodeJ;
      cuPkg::opJal: return cuPkg::opcodeJal;
      default: return cuPkg::opcodeR;
    endcase
  endfunction

  function automatic logic [5:0] functOf(input cuPkg::cuOp o);
    case (o)
      cuPkg::opAdd: return cuPkg::functAdd;
      cuPkg::opSub: return cuPkg::functSub;
      cuPkg::opAnd: return cuPkg::functAnd;
      cuPkg::opSlt: return cuPkg::functSlt;
      cuPkg::opJr: return cuPkg::functJr;
      cuPkg::opMfhi: return cuPkg::functMfhi;
      cuPkg::opMflo: return cuPkg::functMflo;
      cuPkg::opBreak: return cuPkg::functBreak;
      cuPkg::opRte: return cuPkg::functRte;
      default: return 6'd0;
    endcase
  endfunction

  // Search the encoding table; anything unmatched is invalid
  function automatic cuPkg::cuOp classify(input logic [5:0] oc, input logic [5:0] fn);
    cuPkg::cuOp o;
    for (int i = 0; i < OpCount; i++) begin
      o = cuPkg::cuOp'(i);
      if (oc == opcodeOf(o) && (oc != cuPkg::opcodeR || fn == functOf(o))) begin
        return o;
      end
    end
    return cuPkg::opInvalid;
  endfunction

  // Packed as the enables pc a b epc ir reg mem, then aluOp, srcA, srcB, regDst,
  // memToReg, addrSrc, pcSource and resetOut
  function automatic logic [24:0] expectedWord(input cuPkg::cuState s, input cuPkg::cuOp o);
    logic [24:0] w;
    w = {7'b0000000, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB, cuPkg::dstRt,
         cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
    case (s)
      cuPkg::stReset: w[0] = 1'b1;
      cuPkg::stFetchWait: w = {7'b0000000, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                               cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrPc, cuPkg::pcAlu, 1'b0};
      cuPkg::stFetchPc: w = {7'b1000000, cuPkg::aluAdd, cuPkg::srcAPc, cuPkg::srcBFour,
                             cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
      cuPkg::stIrLoad: w[24:18] = 7'b0000100;
      cuPkg::stDecode: w[24:18] = 7'b0110000;
      cuPkg::stOverflow: w = {7'b1001000, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                              cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrOvfVector,
                              cuPkg::pcMemVector, 1'b0};
      cuPkg::stInvalid: w = {7'b1001000, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                             cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrInvVector,
                             cuPkg::pcMemVector, 1'b0};
      cuPkg::stExecute: begin
        case (o)
          cuPkg::opAdd: w = {7'b0000010, cuPkg::aluAdd, cuPkg::srcARegA, cuPkg::srcBRegB,
                             cuPkg::dstRd, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opSub: w = {7'b0000010, cuPkg::aluSub, cuPkg::srcARegA, cuPkg::srcBRegB,
                             cuPkg::dstRd, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opAnd: w = {7'b0000010, cuPkg::aluAnd, cuPkg::srcARegA, cuPkg::srcBRegB,
                             cuPkg::dstRd, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opSlt: w = {7'b0000010, cuPkg::aluSlt, cuPkg::srcARegA, cuPkg::srcBRegB,
                             cuPkg::dstRd, cuPkg::wbSlt, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opAddi,
          cuPkg::opAddiu: w = {7'b0000010, cuPkg::aluAdd, cuPkg::srcARegA, cuPkg::srcBImm,
                               cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opSlti: w = {7'b0000010, cuPkg::aluSlt, cuPkg::srcARegA, cuPkg::srcBImm,
                              cuPkg::dstRt, cuPkg::wbSlt, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opLui: w = {7'b0000010, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                             cuPkg::dstRt, cuPkg::wbLui, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opMfhi: w = {7'b0000010, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                              cuPkg::dstRd, cuPkg::wbHi, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opMflo: w = {7'b0000010, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                              cuPkg::dstRd, cuPkg::wbLo, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opSw: w = {7'b0000001, cuPkg::aluAdd, cuPkg::srcARegA, cuPkg::srcBImm,
                            cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrAlu, cuPkg::pcAlu, 1'b0};
          cuPkg::opJr: w = {7'b1000000, cuPkg::aluNone, cuPkg::srcARegA, cuPkg::srcBRegB,
                            cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opRte: w = {7'b1000000, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                             cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcEpc, 1'b0};
          cuPkg::opBreak: w = {7'b1000000, cuPkg::aluSub, cuPkg::srcAPc, cuPkg::srcBFour,
                               cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcAlu, 1'b0};
          cuPkg::opJ: w = {7'b1000000, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                           cuPkg::dstRt, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcJump, 1'b0};
          cuPkg::opJal: w = {7'b1000010, cuPkg::aluNone, cuPkg::srcAPc, cuPkg::srcBRegB,
                             cuPkg::dstRa, cuPkg::wbAlu, cuPkg::addrNone, cuPkg::pcJump, 1'b0};
          default: ;
        endcase
      end
      default: ;
    endcase
    return w;
  endfunction

  task automatic checkOutputs();
    logic [24:0] want;
    want = expectedWord(expState, expOp);
    checks++;
    assert (gotWord === want) else begin
      $display("FAILED at time %0t: state %s op %s gave control word %h, expected %h",
               $time, expState.name(), expOp.name(), gotWord, want);
      errors++;
    end
  endtask

  // Next model state from the inputs driven this cycle
  task automatic advanceModel();
    if (reset) begin
      expState = cuPkg::stReset;
      expOp = cuPkg::opInvalid;
      waitCnt = 0;
    end else begin
      case (expState)
        cuPkg::stReset: expState = cuPkg::stFetchWait;
        cuPkg::stFetchWait: begin
          if (waitCnt == FetchWait - 1) begin
            waitCnt = 0;
            expState = cuPkg::stFetchPc;
          end else begin
            waitCnt++;
          end
        end
        cuPkg::stFetchPc: expState = cuPkg::stIrLoad;
        cuPkg::stIrLoad: expState = cuPkg::stDecode;
        cuPkg::stDecode: begin
          expOp = classify(opcode, funct);
          expState = (expOp == cuPkg::opInvalid) ? cuPkg::stInvalid : cuPkg::stExecute;
        end
        cuPkg::stExecute: begin
          if (overflow && expOp inside {cuPkg::opAdd, cuPkg::opSub, cuPkg::opAddi}) begin
            expState = cuPkg::stOverflow;
          end else begin
            expState = cuPkg::stFetchWait;
          end
        end
        default: expState = cuPkg::stFetchWait;
      endcase
    end
  endtask

  task automatic runCycle(input logic [5:0] oc, input logic [5:0] fn, input logic ovf,
                          input logic rst);
    @(posedge clk);
    #1;
    checkOutputs();
    reset = rst;
    // Instruction fields only count in decode
    if (expState == cuPkg::stDecode) begin
      opcode = oc;
      funct = fn;
    end else begin
      opcode = 6'($urandom);
      funct = 6'($urandom);
    end
    overflow = (expState == cuPkg::stExecute) ? ovf : 1'($urandom);
    advanceModel();
  endtask

  task automatic runInstr(input logic [5:0] oc, input logic [5:0] fn, input logic ovf);
    bit seenDecode;
    seenDecode = 1'b0;
    do begin
      if (expState == cuPkg::stDecode) begin
        seenDecode = 1'b1;
      end
      runCycle(oc, fn, ovf, 1'b0);
    end while (!(seenDecode && expState == cuPkg::stFetchWait));
  endtask

  task automatic runOp(input cuPkg::cuOp o, input logic ovf);
    logic [5:0] fn;
    fn = (opcodeOf(o) == cuPkg::opcodeR) ? functOf(o) : 6'($urandom);
    runInstr(opcodeOf(o), fn, ovf);
  endtask

  task automatic pickInvalid(output logic [5:0] oc, output logic [5:0] fn);
    do begin
      oc = ($urandom % 2 == 0) ? cuPkg::opcodeR : 6'($urandom);
      fn = 6'($urandom);
    end while (classify(oc, fn) != cuPkg::opInvalid);
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errors == testErrors) begin
      $display("%s: ok", name);
    end else begin
      failedTests++;
      $display("%s: %0d errors", name, errors - testErrors);
    end
    testErrors = errors;
  endtask

  initial begin
    logic [5:0] oc;
    logic [5:0] fn;
    void'($urandom(32'h53ad764d));
    reset = 1'b1;
    opcode = '0;
    funct = '0;
    overflow = 1'b0;
    expState = cuPkg::stReset;
    expOp = cuPkg::opInvalid;
    waitCnt = 0;
    errors = 0;
    checks = 0;
    testErrors = 0;
    testCount = 0;
    failedTests = 0;

    // Reset seen on ten rising edges, then the first fetch cycle
    for (int i = 0; i < 10; i++) begin
      runCycle(6'd0, 6'd0, 1'b0, i < 9);
    end
    runCycle(6'd0, 6'd0, 1'b0, 1'b0);
    endTest("reset and first fetch cycle");

    for (int i = 0; i < OpCount; i++) begin
      runOp(cuPkg::cuOp'(i), 1'b0);
    end
    endTest("each operation, overflow low");

    for (int i = 0; i < OpCount; i++) begin
      runOp(cuPkg::cuOp'(i), 1'b1);
    end
    endTest("each operation, overflow high");

    for (int i = 0; i < InvalidCount; i++) begin
      pickInvalid(oc, fn);
      runInstr(oc, fn, 1'($urandom));
    end
    endTest("invalid encodings");

    for (int i = 0; i < RandomCount; i++) begin
      if ($urandom % 4 == 0) begin
        pickInvalid(oc, fn);
        runInstr(oc, fn, 1'($urandom));
      end else begin
        runOp(cuPkg::cuOp'(5'($urandom % OpCount)), 1'($urandom));
      end
    end
    // Fetch cycle that the last instruction returns to
    runCycle(6'd0, 6'd0, 1'b0, 1'b0);
    endTest("random instruction mix");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             testCount, failedTests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
source/cuPkg.sv
source/opDecoder.sv
source/phaseSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
verification/controlUnit_sva.sv
verification/controlUnitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module controlUnitTb -f tb.f -o simv
./obj_dir/simv | tee sim.log
if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
